// File: logic/device_stream_checker.sv
`timescale 1ns/10ps
`include "ft_defs.svh"

module device_stream_checker
    import ft_proto_pkg::*;
    import ft_model_pkg::*;
(
    input  logic       fifo_clk_o,
    input  logic       ft2232_reset_n_i,
    input  logic       fifo_oe_n_i,
    input  logic       fifo_wr_n_i,
    input  logic [7:0] fifo_data_i,
    output logic       fifo_txe_n_o,
    output logic       abort_o,
    output logic       stop_seen_o,
    output logic       stop_done_o,
    output logic       session_fail_o,
    output logic [7:0] stop_code_o,
    output logic [7:0] stop_received_o,
    output logic [7:0] stop_expected_o
);

    localparam logic [`FT_LEN_W-1:0] LEN_ONE     = 1;
    localparam logic [7:0]           FULL_CYCLES = `FT_IN_FULL_CYCLES;
    localparam logic                 STALLS_ON   = (`FT_IN_FULL_CYCLES != 0);

    ft_byte_u             in_byte;
    logic [1:0]           in_state;
    logic [`FT_CMD_W-1:0] in_cmd;
    logic [`FT_LEN_W-1:0] in_left;
    logic [`FT_LEN_W-1:0] in_total;
    logic [7:0]           in_data;
    logic [7:0]           full_left;

    logic                 write_accept;
    logic [`FT_LEN_W-1:0] left_after;
    logic [`FT_LEN_W-1:0] stop_index;
    logic                 at_stall;
    logic                 stop_capture;

    assign in_byte      = ft_byte_u'(fifo_data_i);
    assign write_accept = ~fifo_txe_n_o & fifo_oe_n_i & ~fifo_wr_n_i;
    assign left_after   = in_left - LEN_ONE;
    assign stop_index   = in_total - in_left;

    // Full FIFO after this byte, only while data remains
    assign at_stall = STALLS_ON && left_after != '0 &&
                      (left_after == (in_total >> STALL_HALF_SHIFT) ||
                       left_after == (in_total >> STALL_QUARTER_SHIFT));

    assign stop_capture = write_accept && in_state == IN_PAYLOAD && in_cmd == CMD_STOPPED;

    // The source is stopped by any failure
    assign abort_o = session_fail_o;

    // ============================================================
    // Inbound sequencer
    // ============================================================
    always_ff @(posedge fifo_clk_o or negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            in_state       <= IN_HDR;
            in_cmd         <= '0;
            in_left        <= '0;
            in_total       <= '0;
            in_data        <= '0;
            full_left      <= '0;
            fifo_txe_n_o   <= 1'b0;
            stop_seen_o    <= 1'b0;
            stop_done_o    <= 1'b0;
            session_fail_o <= 1'b0;
        end else if (fifo_txe_n_o) begin
            if (in_state != IN_IDLE) begin
                full_left <= full_left - 8'd1;
                if (full_left == 8'd1) begin
                    fifo_txe_n_o <= 1'b0;
                end
            end
        end else if (write_accept) begin
            case (in_state)
                IN_HDR: begin
                    case (in_byte.hdr.cmd)
                        CMD_STREAM_CFG, CMD_STREAM_INPUT, CMD_STOPPED: begin
                            in_cmd   <= in_byte.hdr.cmd;
                            in_left  <= in_byte.hdr.len;
                            in_total <= in_byte.hdr.len;
                            // Empty payload keeps waiting for a header
                            if (in_byte.hdr.len != '0) begin
                                in_state <= IN_PAYLOAD;
                            end
                            if (in_byte.hdr.cmd == CMD_STOPPED) begin
                                stop_seen_o <= 1'b1;
                            end
                        end

                        default: begin
                            session_fail_o <= 1'b1;
                            fifo_txe_n_o   <= 1'b1;
                            in_state       <= IN_IDLE;
                        end
                    endcase
                end

                IN_PAYLOAD: begin
                    if (in_cmd == CMD_STREAM_INPUT && fifo_data_i != in_data) begin
                        session_fail_o <= 1'b1;
                        fifo_txe_n_o   <= 1'b1;
                        in_state       <= IN_IDLE;
                    end else begin
                        in_left <= left_after;
                        if (in_left == LEN_ONE) begin
                            in_state <= IN_HDR;
                        end
                        if (in_cmd == CMD_STREAM_INPUT) begin
                            in_data <= in_data + 8'd1;
                            if (at_stall) begin
                                fifo_txe_n_o <= 1'b1;
                                full_left    <= FULL_CYCLES;
                            end
                        end
                        if (in_cmd == CMD_STOPPED && in_left == LEN_ONE) begin
                            stop_done_o <= 1'b1;
                        end
                    end
                end

                default: begin
                    fifo_txe_n_o <= 1'b1;
                end
            endcase
        end
    end

    // Stop report is error code, received value, expected value
    always_ff @(posedge fifo_clk_o) begin
        if (stop_capture) begin
            case (stop_index)
                6'd0:    stop_code_o     <= fifo_data_i;
                6'd1:    stop_received_o <= fifo_data_i;
                6'd2:    stop_expected_o <= fifo_data_i;
                default: stop_code_o     <= stop_code_o;
            endcase
        end
    end

    a_fail_blocks_writes: assert property (@(posedge fifo_clk_o) disable iff (!ft2232_reset_n_i)
        session_fail_o |-> fifo_txe_n_o);

    a_done_or_fail: assert property (@(posedge fifo_clk_o) disable iff (!ft2232_reset_n_i)
        !($rose(stop_done_o) && $rose(session_fail_o)));

endmodule

// File: logic/ft2232_model.sv
`timescale 1ns/10ps

module ft2232_model (
    input  logic       fifo_clk_o,
    input  logic       ft2232_reset_n_i,
    input  logic       fifo_oe_n_i,
    input  logic       fifo_rd_n_i,
    input  logic       fifo_wr_n_i,
    input  logic       fifo_siwu_i,
    input  logic [7:0] fifo_data_i,
    output logic [7:0] fifo_data_o,
    output logic       fifo_rxf_n_o,
    output logic       fifo_txe_n_o,
    output logic       stop_done_o,
    output logic       session_fail_o,
    output logic [7:0] stop_code_o,
    output logic [7:0] stop_received_o,
    output logic [7:0] stop_expected_o
);

    // Sticky session flags from the checker to the source
    logic abort;
    logic stop_seen;

    host_stream_source u_source (
        .fifo_clk_o       (fifo_clk_o),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .fifo_oe_n_i      (fifo_oe_n_i),
        .fifo_rd_n_i      (fifo_rd_n_i),
        .abort_i          (abort),
        .stop_seen_i      (stop_seen),
        .fifo_data_o      (fifo_data_o),
        .fifo_rxf_n_o     (fifo_rxf_n_o)
    );

    device_stream_checker u_checker (
        .fifo_clk_o       (fifo_clk_o),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .fifo_oe_n_i      (fifo_oe_n_i),
        .fifo_wr_n_i      (fifo_wr_n_i),
        .fifo_data_i      (fifo_data_i),
        .fifo_txe_n_o     (fifo_txe_n_o),
        .abort_o          (abort),
        .stop_seen_o      (stop_seen),
        .stop_done_o      (stop_done_o),
        .session_fail_o   (session_fail_o),
        .stop_code_o      (stop_code_o),
        .stop_received_o  (stop_received_o),
        .stop_expected_o  (stop_expected_o)
    );

endmodule

// File: logic/ft_defs.svh
`ifndef FT_DEFS_SVH
`define FT_DEFS_SVH

// ============================================================
// Outbound session shape
// ============================================================

// Data packets sent after the configuration byte
`define FT_DATA_PACKETS 8'd3

// Payload bytes carried by each outbound data packet
`define FT_PACKET_PAYLOAD 6'd60

// Stall lengths in clocks, zero turns the stall off
`define FT_OUT_EMPTY_CYCLES 8'd4
`define FT_IN_FULL_CYCLES 8'd3

// ============================================================
// Header field widths
// ============================================================
`define FT_CMD_W 2
`define FT_LEN_W 6

`endif

// File: logic/ft_model_pkg.sv
package ft_model_pkg;

    // ============================================================
    // Outbound sequencer, named after the byte on the bus
    // ============================================================
    localparam logic [2:0] OUT_SETUP_HDR = 3'd0;
    localparam logic [2:0] OUT_CFG       = 3'd1;
    localparam logic [2:0] OUT_DATA_HDR  = 3'd2;
    localparam logic [2:0] OUT_DATA      = 3'd3;
    localparam logic [2:0] OUT_STOP_HDR  = 3'd4;
    localparam logic [2:0] OUT_IDLE      = 3'd5;

    // ============================================================
    // Inbound sequencer
    // ============================================================
    localparam logic [1:0] IN_HDR     = 2'd0;
    localparam logic [1:0] IN_PAYLOAD = 2'd1;
    localparam logic [1:0] IN_IDLE    = 2'd3;

    // Stall points sit where the remaining count equals the
    // packet length shifted right by one or by two
    localparam int unsigned STALL_HALF_SHIFT    = 1;
    localparam int unsigned STALL_QUARTER_SHIFT = 2;

endpackage

// File: logic/ft_proto_pkg.sv
`include "ft_defs.svh"

package ft_proto_pkg;

    // Host to device commands
    localparam logic [`FT_CMD_W-1:0] CMD_SETUP_OUTPUT  = 2'd1;
    localparam logic [`FT_CMD_W-1:0] CMD_STREAM_OUTPUT = 2'd2;
    localparam logic [`FT_CMD_W-1:0] CMD_STOP          = 2'd3;

    // Device to host commands, code 0 is not defined
    localparam logic [`FT_CMD_W-1:0] CMD_STREAM_CFG    = 2'd1;
    localparam logic [`FT_CMD_W-1:0] CMD_STREAM_INPUT  = 2'd2;
    localparam logic [`FT_CMD_W-1:0] CMD_STOPPED       = 2'd3;

    // Stream configuration fields
    localparam logic       CHANNELS_STEREO = 1'b1;
    localparam logic [1:0] IO_TYPE_BNC     = 2'd1;
    localparam logic [2:0] STREAM_48000_HZ = 3'd1;
    localparam logic [1:0] BIT_DEPTH_24    = 2'd2;

    localparam logic [7:0] STREAM_CFG_BYTE =
        {CHANNELS_STEREO, IO_TYPE_BNC, STREAM_48000_HZ, BIT_DEPTH_24};

    // One bus byte, read either as a header or as a configuration byte
    typedef union packed {
        struct packed {
            logic [`FT_CMD_W-1:0] cmd;
            logic [`FT_LEN_W-1:0] len;
        } hdr;
        struct packed {
            logic       channels;
            logic [1:0] io_type;
            logic [2:0] rate;
            logic [1:0] depth;
        } cfg;
    } ft_byte_u;

endpackage

// File: logic/host_stream_source.sv
`timescale 1ns/10ps
`include "ft_defs.svh"

module host_stream_source
    import ft_proto_pkg::*;
    import ft_model_pkg::*;
(
    input  logic       fifo_clk_o,
    input  logic       ft2232_reset_n_i,
    input  logic       fifo_oe_n_i,
    input  logic       fifo_rd_n_i,
    input  logic       abort_i,
    input  logic       stop_seen_i,
    output logic [7:0] fifo_data_o,
    output logic       fifo_rxf_n_o
);

    function automatic ft_byte_u make_hdr(input logic [`FT_CMD_W-1:0] cmd,
                                          input logic [`FT_LEN_W-1:0] len);
        ft_byte_u b;
        b.hdr.cmd = cmd;
        b.hdr.len = len;
        return b;
    endfunction

    function automatic ft_byte_u make_cfg();
        ft_byte_u b;
        b.cfg.channels = CHANNELS_STEREO;
        b.cfg.io_type  = IO_TYPE_BNC;
        b.cfg.rate     = STREAM_48000_HZ;
        b.cfg.depth    = BIT_DEPTH_24;
        return b;
    endfunction

    localparam logic [`FT_LEN_W-1:0] PAYLOAD     = `FT_PACKET_PAYLOAD;
    localparam logic [`FT_LEN_W-1:0] LEN_ONE     = 1;
    localparam logic [`FT_LEN_W-1:0] HALF_POS    = PAYLOAD >> STALL_HALF_SHIFT;
    localparam logic [`FT_LEN_W-1:0] QUARTER_POS = PAYLOAD >> STALL_QUARTER_SHIFT;
    localparam logic [7:0]           EMPTY_CYCLES = `FT_OUT_EMPTY_CYCLES;
    localparam logic                 STALLS_ON   = (`FT_OUT_EMPTY_CYCLES != 0);

    localparam ft_byte_u SETUP_HDR = make_hdr(CMD_SETUP_OUTPUT, LEN_ONE);
    localparam ft_byte_u CFG_BYTE  = make_cfg();
    localparam ft_byte_u DATA_HDR  = make_hdr(CMD_STREAM_OUTPUT, PAYLOAD);
    localparam ft_byte_u STOP_HDR  = make_hdr(CMD_STOP, '0);

    logic [2:0]           out_state;
    logic [7:0]           packets_left;
    logic [`FT_LEN_W-1:0] payload_left;
    logic [7:0]           out_data;
    logic [7:0]           empty_left;
    logic                 half_done;
    logic                 quarter_done;

    logic                 read_accept;
    logic [`FT_LEN_W-1:0] next_left;
    logic                 half_armed;
    logic                 quarter_armed;
    logic                 hit_half;
    logic                 hit_quarter;

    assign read_accept = ~fifo_rxf_n_o & ~fifo_oe_n_i & ~fifo_rd_n_i;

    // Remaining count of the data byte loaded by the next read
    always_comb begin
        if (out_state == OUT_DATA_HDR) begin
            next_left     = PAYLOAD;
            half_armed    = 1'b1;
            quarter_armed = 1'b1;
        end else begin
            next_left     = payload_left - LEN_ONE;
            half_armed    = ~half_done;
            quarter_armed = ~quarter_done;
        end
        hit_half    = STALLS_ON & half_armed & (next_left == HALF_POS);
        hit_quarter = STALLS_ON & quarter_armed & (next_left == QUARTER_POS);
    end

    // ============================================================
    // Outbound sequencer
    // ============================================================
    always_ff @(posedge fifo_clk_o or negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            out_state    <= OUT_SETUP_HDR;
            fifo_data_o  <= SETUP_HDR;
            fifo_rxf_n_o <= 1'b0;
            packets_left <= `FT_DATA_PACKETS;
            payload_left <= '0;
            out_data     <= '0;
            empty_left   <= '0;
            half_done    <= 1'b0;
            quarter_done <= 1'b0;
        end else if ((abort_i || stop_seen_i) && out_state != OUT_IDLE) begin
            out_state    <= OUT_IDLE;
            fifo_rxf_n_o <= 1'b1;
        end else if (fifo_rxf_n_o) begin
            // Empty FIFO countdown, idle holds RXF# high for good
            if (out_state != OUT_IDLE) begin
                empty_left <= empty_left - 8'd1;
                if (empty_left == 8'd1) begin
                    fifo_rxf_n_o <= 1'b0;
                end
            end
        end else if (read_accept) begin
            case (out_state)
                OUT_SETUP_HDR: begin
                    fifo_data_o <= CFG_BYTE;
                    out_state   <= OUT_CFG;
                end

                OUT_CFG: begin
                    fifo_data_o <= DATA_HDR;
                    out_state   <= OUT_DATA_HDR;
                end

                OUT_DATA_HDR, OUT_DATA: begin
                    if (out_state == OUT_DATA && payload_left == LEN_ONE) begin
                        // Last byte of the packet was taken
                        packets_left <= packets_left - 8'd1;
                        if (packets_left == 8'd1) begin
                            fifo_data_o <= STOP_HDR;
                            out_state   <= OUT_STOP_HDR;
                        end else begin
                            fifo_data_o <= DATA_HDR;
                            out_state   <= OUT_DATA_HDR;
                        end
                    end else begin
                        fifo_data_o  <= out_data;
                        out_data     <= out_data + 8'd1;
                        payload_left <= next_left;
                        out_state    <= OUT_DATA;
                        half_done    <= ~half_armed | hit_half;
                        quarter_done <= ~quarter_armed | hit_quarter;
                        if (hit_half || hit_quarter) begin
                            fifo_rxf_n_o <= 1'b1;
                            empty_left   <= EMPTY_CYCLES;
                        end
                    end
                end

                default: begin
                    out_state    <= OUT_IDLE;
                    fifo_rxf_n_o <= 1'b1;
                end
            endcase
        end
    end

    a_idle_rxf_high: assert property (@(posedge fifo_clk_o) disable iff (!ft2232_reset_n_i)
        out_state == OUT_IDLE |-> fifo_rxf_n_o);

endmodule

// File: sim/tb_ft2232_model.sv
`timescale 1ns/10ps
`include "ft_defs.svh"

module tb_ft2232_model;

    localparam int PAYLOAD = `FT_PACKET_PAYLOAD;
    localparam int TIMEOUT = 5000;

    logic       fifo_clk_o;
    logic       ft2232_reset_n_i;
    logic       fifo_oe_n_i;
    logic       fifo_rd_n_i;
    logic       fifo_wr_n_i;
    logic       fifo_siwu_i;
    logic [7:0] fifo_data_i;
    logic [7:0] fifo_data_o;
    logic       fifo_rxf_n_o;
    logic       fifo_txe_n_o;
    logic       stop_done_o;
    logic       session_fail_o;
    logic [7:0] stop_code_o;
    logic [7:0] stop_received_o;
    logic [7:0] stop_expected_o;

    string      test_names [1:6];
    int         test_errors [1:6];
    int         errors;
    int         checks;
    logic [7:0] out_exp [0:255];
    bit         out_stall [0:255];
    int         out_runs [0:255];
    int         out_total;
    int         out_idx;
    int         rxf_run;
    int         out_test;
    int         in_test;
    bit         track;
    logic [7:0] in_q [$];
    bit         in_flag [$];
    int         in_count;
    int         writes;
    int         txe_run;
    int         txe_runs;
    int         stall_writes;
    bit         last_flag;

    ft2232_model uut (.*);

    initial begin
        fifo_clk_o = 1'b0;
        forever #10 fifo_clk_o = ~fifo_clk_o;
    end

    task automatic compare(input int id, input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            test_errors[id]++;
            $display("Fail %s: expected %0h, actual %0h", test_names[id], expected, actual);
        end
    endtask

    task automatic report_timeout(input int id, input string what);
        errors++;
        test_errors[id]++;
        $display("Timeout in %s while waiting for %s", test_names[id], what);
    endtask

    task automatic finish_test(input int id);
        $display("Test %0d %s: %s (%0d errors)", id, test_names[id],
                 (test_errors[id] == 0) ? "PASS" : "FAIL", test_errors[id]);
    endtask

    // ============================================================
    // Reference streams
    // ============================================================

    // Setup header, config byte, data packets, stop header
    task automatic build_outbound();
        int n;
        int p;
        int j;
        int rem;
        for (j = 0; j < 256; j++) begin
            out_stall[j] = 1'b0;
            out_runs[j]  = 0;
        end
        out_exp[0] = 8'h41;
        out_exp[1] = 8'hA6;
        n = 2;
        for (p = 0; p < `FT_DATA_PACKETS; p++) begin
            out_exp[n] = {2'd2, 6'(PAYLOAD)};
            n = n + 1;
            for (j = 0; j < PAYLOAD; j++) begin
                rem          = PAYLOAD - j;
                out_exp[n]   = 8'(p * PAYLOAD + j);
                out_stall[n] = (`FT_OUT_EMPTY_CYCLES != 0) &&
                               (rem == (PAYLOAD >> 1) || rem == (PAYLOAD >> 2));
                n = n + 1;
            end
        end
        out_exp[n] = {2'd3, 6'd0};
        out_total  = n + 1;
    endtask

    // Stream-input packet, flag marks bytes that leave a stall position
    task automatic push_stream_packet(input int len);
        int k;
        int rem;
        in_q.push_back({2'd2, 6'(len)});
        in_flag.push_back(1'b0);
        for (k = 0; k < len; k++) begin
            rem = len - 1 - k;
            in_q.push_back(8'(in_count));
            in_flag.push_back((`FT_IN_FULL_CYCLES != 0) && rem != 0 &&
                              (rem == (len >> 1) || rem == (len >> 2)));
            in_count++;
        end
    endtask

    task automatic reset_dut();
        ft2232_reset_n_i = 1'b0;
        fifo_oe_n_i      = 1'b1;
        fifo_rd_n_i      = 1'b1;
        fifo_wr_n_i      = 1'b1;
        fifo_data_i      = 8'h00;
        in_q.delete();
        in_flag.delete();
        out_idx      = 0;
        rxf_run      = 0;
        txe_run      = 0;
        txe_runs     = 0;
        stall_writes = 0;
        last_flag    = 1'b0;
        writes       = 0;
        repeat (4) @(negedge fifo_clk_o);
        ft2232_reset_n_i = 1'b1;
    endtask

    // ============================================================
    // One clock of device-side activity
    // ============================================================
    task automatic step();
        bit read_go;
        bit write_go;
        @(negedge fifo_clk_o);
        if (track) begin
            if (out_idx < out_total) begin
                if (fifo_rxf_n_o) begin
                    rxf_run++;
                end else if (rxf_run != 0) begin
                    // Stall just ended, the byte on the bus must be a stall point
                    compare(2, `FT_OUT_EMPTY_CYCLES, rxf_run);
                    compare(2, 1, out_stall[out_idx]);
                    out_runs[out_idx]++;
                    rxf_run = 0;
                end
            end else begin
                compare(out_test, 1, fifo_rxf_n_o);
            end
            if (fifo_txe_n_o) begin
                txe_run++;
            end else if (txe_run != 0) begin
                compare(in_test, `FT_IN_FULL_CYCLES, txe_run);
                compare(in_test, 1, last_flag);
                txe_runs++;
                txe_run = 0;
            end
            compare(in_test, 0, session_fail_o);
        end
        fifo_oe_n_i = 1'($urandom % 2);
        fifo_rd_n_i = ($urandom % 4) == 0;
        fifo_wr_n_i = (in_q.size() == 0) || (($urandom % 4) == 0);
        if (in_q.size() != 0) begin
            fifo_data_i = in_q[0];
        end else begin
            fifo_data_i = 8'($urandom);
        end
        // Transfers that the next rising edge will perform
        read_go  = !fifo_rxf_n_o && !fifo_oe_n_i && !fifo_rd_n_i;
        write_go = !fifo_txe_n_o && fifo_oe_n_i && !fifo_wr_n_i;
        if (read_go && track && out_idx < out_total) begin
            compare(1, out_exp[out_idx], fifo_data_o);
            out_idx++;
        end
        if (write_go) begin
            last_flag = in_flag.pop_front();
            void'(in_q.pop_front());
            stall_writes += last_flag;
            writes++;
        end
    endtask

    initial begin
        int         cycles;
        int         i;
        logic [7:0] stop_bytes [0:2];
        void'($urandom(32'hc746_913a));
        test_names[1] = "outbound_stream";
        test_names[2] = "outbound_stalls";
        test_names[3] = "inbound_streaming";
        test_names[4] = "stop_report";
        test_names[5] = "data_mismatch";
        test_names[6] = "unknown_command";
        for (i = 1; i <= 6; i++) begin
            test_errors[i] = 0;
        end
        errors      = 0;
        checks      = 0;
        in_count    = 0;
        fifo_siwu_i = 1'b1;
        track       = 1'b0;
        build_outbound();
        reset_dut();

        // Tests 1 to 3 share one session
        track    = 1'b1;
        out_test = 1;
        in_test  = 3;
        in_q.push_back({2'd1, 6'd1});
        in_flag.push_back(1'b0);
        in_q.push_back(8'hA6);
        in_flag.push_back(1'b0);
        repeat (4) push_stream_packet(8 + $urandom % 56);
        cycles = 0;
        while ((out_idx < out_total || in_q.size() != 0) && cycles < TIMEOUT) begin
            step();
            cycles++;
        end
        if (out_idx < out_total || in_q.size() != 0) begin
            report_timeout(1, "the outbound and inbound streams to finish");
        end
        repeat (2 * `FT_OUT_EMPTY_CYCLES + 2) step();
        for (i = 0; i < out_total; i++) begin
            if (out_stall[i]) begin
                compare(2, 1, out_runs[i]);
            end
        end
        compare(3, stall_writes, txe_runs);
        finish_test(1);
        finish_test(2);
        finish_test(3);

        out_test = 4;
        in_test  = 4;
        in_q.push_back({2'd3, 6'd3});
        in_flag.push_back(1'b0);
        for (i = 0; i < 3; i++) begin
            stop_bytes[i] = 8'($urandom);
            in_q.push_back(stop_bytes[i]);
            in_flag.push_back(1'b0);
        end
        cycles = 0;
        while (!stop_done_o && cycles < TIMEOUT) begin
            step();
            cycles++;
        end
        if (!stop_done_o) begin
            report_timeout(4, "stop_done_o");
        end
        compare(4, stop_bytes[0], stop_code_o);
        compare(4, stop_bytes[1], stop_received_o);
        compare(4, stop_bytes[2], stop_expected_o);
        repeat (4) step();
        finish_test(4);

        // Third payload byte is off the counter
        track = 1'b0;
        reset_dut();
        in_q.push_back({2'd2, 6'd8});
        in_flag.push_back(1'b0);
        for (i = 0; i < 8; i++) begin
            if (i == 2) begin
                in_q.push_back(8'd3 + 8'($urandom % 200));
            end else begin
                in_q.push_back(8'(i));
            end
            in_flag.push_back(1'b0);
        end
        cycles = 0;
        while (!session_fail_o && cycles < TIMEOUT) begin
            step();
            cycles++;
        end
        if (!session_fail_o) begin
            report_timeout(5, "session_fail_o");
        end
        compare(5, 4, writes);
        cycles = 0;
        while (!fifo_rxf_n_o && cycles < TIMEOUT) begin
            step();
            cycles++;
        end
        if (!fifo_rxf_n_o) begin
            report_timeout(5, "fifo_rxf_n_o");
        end
        // Still high after any stall would have ended
        repeat (`FT_OUT_EMPTY_CYCLES + 2) step();
        compare(5, 1, fifo_txe_n_o);
        compare(5, 1, fifo_rxf_n_o);
        finish_test(5);

        reset_dut();
        in_q.push_back({2'd0, 6'd0});
        in_flag.push_back(1'b0);
        // Stop report queued behind the bad header
        in_q.push_back({2'd3, 6'd3});
        in_flag.push_back(1'b0);
        for (i = 0; i < 3; i++) begin
            in_q.push_back(8'($urandom));
            in_flag.push_back(1'b0);
        end
        cycles = 0;
        while (!session_fail_o && cycles < TIMEOUT) begin
            step();
            cycles++;
        end
        if (!session_fail_o) begin
            report_timeout(6, "session_fail_o");
        end
        repeat (4) step();
        compare(6, 0, stop_done_o);
        finish_test(6);

        $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+logic
logic/ft_proto_pkg.sv
logic/ft_model_pkg.sv
logic/host_stream_source.sv
logic/device_stream_checker.sv
logic/ft2232_model.sv
sim/tb_ft2232_model.sv
